/* flist.f */
+incdir+include
verilog/mem_pkg.sv
verilog/ram.sv
verilog/cache_ctrl.sv
verilog/pwm_timer.sv
verilog/peripheral_manager.sv
verilog/mmu.sv
verilog/mem_subsystem.sv
tests/mem_subsystem_tb.sv

/* tests/mem_input.txt */
# test op address data expected (address, data and expected in hex)
# R read, W write, B buttons (data bit 0 btn1, bit 1 btn2), P PWM (data window cycles, expected highs)
1 W 00000010 deadbeef 00000000
1 R 00000010 00000000 deadbeef
2 W 00000050 12345678 00000000
2 R 00000010 00000000 deadbeef
2 R 00000050 00000000 12345678
2 R 00000010 00000000 deadbeef
3 W 00000010 cafef00d 00000000
3 R 00000010 00000000 cafef00d
4 W 80000004 00000003 00000000
4 W 80000008 00000009 00000000
4 R 80000004 00000000 00000003
4 R 80000008 00000000 00000009
5 B 00000000 00000002 00000000
5 R 80000000 00000000 00000002
5 B 00000000 00000001 00000000
5 R 80000000 00000000 00000001
6 W 80000004 00000005 00000000
6 W 80000008 0000000f 00000000
6 P 00000000 00000010 00000005
6 W 80000004 00000014 00000000
6 W 80000008 00000007 00000000
6 P 00000000 00000008 00000008
6 W 80000004 00000000 00000000
6 P 00000000 00000008 00000000

/* tests/mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb;
    import mem_pkg::*;

    logic  clk;
    logic  rst;
    addr_t address;
    word_t data_in;
    logic  write_enable;
    logic  read_enable;
    logic  btn1;
    logic  btn2;
    word_t data_out;
    logic  data_ready;
    logic  port_pwm1;

    // One entry per line of the data file
    int    op_test[$];
    byte   op_kind[$];
    addr_t op_addr[$];
    word_t op_data[$];
    word_t op_exp[$];

    int cycles = 0;
    int cycle_limit = 0;        // Zero until the data file is loaded
    int test_checks = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    mem_subsystem dut_i (
        .clk          (clk),
        .rst          (rst),
        .address      (address),
        .data_in      (data_in),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .btn1         (btn1),
        .btn2         (btn2),
        .data_out     (data_out),
        .data_ready   (data_ready),
        .port_pwm1    (port_pwm1)
    );

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic load_ops(output bit ok);
        int    fd;
        int    n;
        string line;
        int    t;
        byte   k;
        addr_t a;
        word_t d;
        word_t e;
        ok = 1'b0;
        fd = $fopen("tests/mem_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin      // Skip column notes
                    n = $sscanf(line, "%d %c %h %h %h", t, k, a, d, e);
                    if (n == 5) begin
                        op_test.push_back(t);
                        op_kind.push_back(k);
                        op_addr.push_back(a);
                        op_data.push_back(d);
                        op_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
            ok = (op_test.size() > 0);
        end
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        test_checks++;
        assert (actual === expected) else begin
            $display("FAILED time=%0t %s expected %h got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    // One request held until the reply
    task automatic do_request(addr_t a, word_t d, bit wr, word_t expected);
        @(posedge clk);
        address      <= a;
        data_in      <= d;
        write_enable <= wr;
        read_enable  <= !wr;
        do @(negedge clk); while (data_ready !== 1'b1);
        if (!wr) begin
            check_value("data_out", expected, data_out);
        end
    endtask

    task automatic set_buttons(word_t d);
        @(posedge clk);
        write_enable <= 1'b0;
        read_enable  <= 1'b0;
        btn1         <= d[0];
        btn2         <= d[1];
        repeat (4) @(posedge clk);      // Through the synchronizer
    endtask

    // Count high cycles of port_pwm1 over one PWM period
    task automatic measure_pwm(int window, word_t expected);
        int high;
        high = 0;
        @(posedge clk);
        write_enable <= 1'b0;
        read_enable  <= 1'b0;
        repeat (2 * window) @(posedge clk);     // Counter settles on the new period
        repeat (window) begin
            @(negedge clk);
            if (port_pwm1 === 1'b1) begin
                high++;
            end
        end
        check_value("port_pwm1 high cycles", expected, word_t'(high));
    endtask

    task automatic report_test(int num);
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d passed, %0d checks", num, test_checks);
        end else begin
            tests_failed++;
            $display("Test %0d failed, %0d of %0d checks wrong", num, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        bit ok;
        int gap;
        clk          = 1'b0;
        rst          = 1'b1;
        address      = '0;
        data_in      = '0;
        write_enable = 1'b0;
        read_enable  = 1'b0;
        btn1         = 1'b0;
        btn2         = 1'b0;
        void'($urandom(32'h34e80ed5));
        load_ops(ok);
        if (!ok) begin
            $display("Could not read any operations from tests/mem_input.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            cycle_limit = 40 * op_test.size() + 600;
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            foreach (op_test[i]) begin
                if (i > 0 && op_test[i] != op_test[i-1]) begin
                    report_test(op_test[i-1]);
                end
                case (op_kind[i])
                    "R": do_request(op_addr[i], op_data[i], 1'b0, op_exp[i]);
                    "W": do_request(op_addr[i], op_data[i], 1'b1, op_exp[i]);
                    "B": set_buttons(op_data[i]);
                    "P": measure_pwm(int'(op_data[i]), op_exp[i]);
                    default: begin
                        $display("Test %0d has an unknown operation '%c' in the data file",
                                 op_test[i], op_kind[i]);
                        test_errors++;
                    end
                endcase
                // Idle gap of zero means back to back
                gap = $urandom_range(3, 0);
                if (gap > 0) begin
                    @(posedge clk);
                    write_enable <= 1'b0;
                    read_enable  <= 1'b0;
                    repeat (gap - 1) @(posedge clk);
                end
            end
            report_test(op_test[op_test.size()-1]);
            $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

/* verilog/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t address,
    input  mem_pkg::word_t data_in,
    input  logic           write_enable,
    input  logic           read_enable,
    input  logic           btn1,
    input  logic           btn2,
    output mem_pkg::word_t data_out,
    output logic           data_ready,
    output logic           port_pwm1
);
    import mem_pkg::*;

    // mmu to L1D
    addr_t l1d_address;
    word_t l1d_data_in, l1d_data_out;
    logic  l1d_write_enable, l1d_read_enable, l1d_data_ready;

    // L1D to RAM
    addr_t ram_address;
    word_t ram_data_in, ram_data_out;
    logic  ram_write_enable;

    // mmu to peripherals
    addr_t p_address;
    word_t p_data_in, p_data_out;
    logic  p_write_enable, p_read_enable, p_data_ready;

    mmu mmu_i (
        .clk            (clk),
        .rst            (rst),
        .c_address      (address),
        .c_data_in      (data_in),
        .c_write_enable (write_enable),
        .c_read_enable  (read_enable),
        .c_data_ready   (data_ready),
        .c_data_out     (data_out),
        .m_address      (l1d_address),
        .m_data_in      (l1d_data_in),
        .m_write_enable (l1d_write_enable),
        .m_read_enable  (l1d_read_enable),
        .m_data_ready   (l1d_data_ready),
        .m_data_out     (l1d_data_out),
        .p_address      (p_address),
        .p_data_in      (p_data_in),
        .p_write_enable (p_write_enable),
        .p_read_enable  (p_read_enable),
        .p_data_ready   (p_data_ready),
        .p_data_out     (p_data_out)
    );

    cache_ctrl l1d_i (
        .clk                (clk),
        .rst                (rst),
        .address            (l1d_address),
        .data_in            (l1d_data_in),
        .write_enable       (l1d_write_enable),
        .read_enable        (l1d_read_enable),
        .data_ready         (l1d_data_ready),
        .data_out           (l1d_data_out),
        .fetch_address      (ram_address),
        .fetch_write_data   (ram_data_in),
        .fetch_write_enable (ram_write_enable),
        .fetch_read_data    (ram_data_out)
    );

    ram ram_i (
        .clk          (clk),
        .rst          (rst),
        .address      (ram_address),
        .data_in      (ram_data_in),
        .write_enable (ram_write_enable),
        .data_out     (ram_data_out)
    );

    peripheral_manager periph_i (
        .clk          (clk),
        .rst          (rst),
        .addr         (p_address),
        .data_in      (p_data_in),
        .write_enable (p_write_enable),
        .read_enable  (p_read_enable),
        .btn1         (btn1),
        .btn2         (btn2),
        .data_out     (p_data_out),
        .data_ready   (p_data_ready),
        .pwm1_out     (port_pwm1)
    );

endmodule

/* verilog/mmu.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module mmu (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t c_address,
    input  mem_pkg::word_t c_data_in,
    input  logic           c_write_enable,
    input  logic           c_read_enable,
    output logic           c_data_ready,
    output mem_pkg::word_t c_data_out,
    output mem_pkg::addr_t m_address,
    output mem_pkg::word_t m_data_in,
    output logic           m_write_enable,
    output logic           m_read_enable,
    input  logic           m_data_ready,
    input  mem_pkg::word_t m_data_out,
    output mem_pkg::addr_t p_address,
    output mem_pkg::word_t p_data_in,
    output logic           p_write_enable,
    output logic           p_read_enable,
    input  logic           p_data_ready,
    input  mem_pkg::word_t p_data_out
);
    import mem_pkg::*;

    logic busy;                 // Request open and waiting for its reply
    logic owner_periph;
    logic sel_periph;
    logic c_request;

    assign c_request  = c_write_enable || c_read_enable;
    assign sel_periph = busy ? owner_periph : c_address[`PERIPH_SEL_BIT];

    // Latch the target when a request opens
    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            owner_periph <= 1'b0;
        end else if (c_data_ready) begin
            busy <= 1'b0;
        end else if (c_request && !busy) begin
            busy         <= 1'b1;
            owner_periph <= c_address[`PERIPH_SEL_BIT];
        end
    end

    assign m_address      = c_address;
    assign m_data_in      = c_data_in;
    assign m_write_enable = c_write_enable && !sel_periph;
    assign m_read_enable  = c_read_enable && !sel_periph;

    assign p_data_in      = c_data_in;
    assign p_write_enable = c_write_enable && sel_periph;
    assign p_read_enable  = c_read_enable && sel_periph;

    always_comb begin
        p_address                  = c_address;
        p_address[`PERIPH_SEL_BIT] = 1'b0;     // Offset inside the peripheral block
    end

    assign c_data_ready = sel_periph ? p_data_ready : m_data_ready;
    assign c_data_out   = sel_periph ? p_data_out : m_data_out;

    // Only the side that owns the request may be active and reply
    assert property (@(posedge clk) disable iff (rst)
        !(sel_periph ? m_data_ready : p_data_ready))
        else $error("reply from the side that does not own the request");

endmodule

/* verilog/peripheral_manager.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module peripheral_manager (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::word_t data_in,
    input  logic           write_enable,
    input  logic           read_enable,
    input  logic           btn1,
    input  logic           btn2,
    output mem_pkg::word_t data_out,
    output logic           data_ready,
    output logic           pwm1_out
);
    import mem_pkg::*;

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;       // btn2 in bit 1, btn1 in bit 0
    pwm_t duty_q;
    pwm_t period_q;
    logic accept;

    // Ignores the request still held in the cycle of the reply
    assign accept = (write_enable || read_enable) && !data_ready;

    // Two-flop synchronizers for the buttons
    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= {btn2, btn1};
            btn_sync <= btn_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            duty_q     <= '0;
            period_q   <= '0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= accept;
            if (accept && write_enable) begin
                case (addr)
                    addr_t'(`PERIPH_DUTY_OFS):   duty_q   <= data_in[`PWM_W-1:0];
                    addr_t'(`PERIPH_PERIOD_OFS): period_q <= data_in[`PWM_W-1:0];
                    default: ;      // Button register is read-only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && read_enable) begin
            case (addr)
                addr_t'(`PERIPH_BTN_OFS):    data_out <= word_t'(btn_sync);
                addr_t'(`PERIPH_DUTY_OFS):   data_out <= word_t'(duty_q);
                addr_t'(`PERIPH_PERIOD_OFS): data_out <= word_t'(period_q);
                default:                     data_out <= '0;
            endcase
        end
    end

    pwm_timer pwm_timer_i (
        .clk    (clk),
        .rst    (rst),
        .duty   (duty_q),
        .period (period_q),
        .pwm    (pwm1_out)
    );

endmodule

/* verilog/pwm_timer.sv */
`timescale 1ns/1ps

module pwm_timer (
    input  logic          clk,
    input  logic          rst,
    input  mem_pkg::pwm_t duty,
    input  mem_pkg::pwm_t period,
    output logic          pwm
);
    import mem_pkg::*;

    pwm_t count;

    // Runs 0..period, so one PWM period is period+1 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (count >= period) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Duty above period keeps the output high
    always_ff @(posedge clk) begin
        if (rst) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (count < duty);
        end
    end

endmodule

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t address,
    input  mem_pkg::word_t data_in,
    input  logic           write_enable,
    input  logic           read_enable,
    output logic           data_ready,
    output mem_pkg::word_t data_out,
    output mem_pkg::addr_t fetch_address,
    output mem_pkg::word_t fetch_write_data,
    output logic           fetch_write_enable,
    input  mem_pkg::word_t fetch_read_data
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`CACHE_LINES);

    cache_state_t state;

    // Tag and data arrays with one word per line
    word_t line_data [`CACHE_LINES];
    tag_t  line_tag  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] line_valid;

    logic [IDX_W-1:0] index;
    tag_t tag;
    logic hit;
    logic request;

    assign index   = address[IDX_W+1:2];
    assign tag     = address[`MEM_ADDR_W-1:IDX_W+2];
    assign hit     = line_valid[index] && (line_tag[index] == tag);
    assign request = write_enable || read_enable;

    // Core holds the request, so the RAM side can follow it directly
    assign fetch_address    = address;
    assign fetch_write_data = data_in;

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            data_ready         <= 1'b0;
            fetch_write_enable <= 1'b0;
            line_valid         <= '0;
        end else begin
            data_ready <= 1'b0;
            case (state)
                IDLE: begin
                    // Skip the cycle in which the last reply is still up
                    if (request && !data_ready) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (write_enable) begin
                        fetch_write_enable <= 1'b1;     // Write-through on a hit or a miss
                        state              <= WRITE;
                    end else if (hit) begin
                        data_ready <= 1'b1;
                        state      <= IDLE;
                    end else begin
                        state <= FETCH;
                    end
                end
                FETCH: state <= FILL;                   // RAM read in flight
                FILL: begin
                    line_valid[index] <= 1'b1;
                    data_ready        <= 1'b1;
                    state             <= IDLE;
                end
                WRITE: begin
                    fetch_write_enable <= 1'b0;
                    data_ready         <= 1'b1;
                    state              <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Line contents and reply data
    always_ff @(posedge clk) begin
        case (state)
            LOOKUP: begin
                if (!write_enable && hit) begin
                    data_out <= line_data[index];
                end
            end
            FILL: begin
                line_data[index] <= fetch_read_data;
                line_tag[index]  <= tag;
                data_out         <= fetch_read_data;
            end
            WRITE: begin
                // No allocate on a write miss
                if (hit) begin
                    line_data[index] <= data_in;
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) data_ready |=> !data_ready)
        else $error("cache data_ready held for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) fetch_write_enable |-> state == WRITE)
        else $error("RAM write outside the WRITE state");

endmodule

/* verilog/ram.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module ram (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t address,
    input  mem_pkg::word_t data_in,
    input  logic           write_enable,
    output mem_pkg::word_t data_out
);
    import mem_pkg::*;

    localparam int WORD_AW = $clog2(`RAM_DEPTH);

    word_t mem [`RAM_DEPTH];
    logic [WORD_AW-1:0] word_index;

    // Byte address to word index
    assign word_index = address[WORD_AW+1:2];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[word_index] <= data_in;
        end
    end

    // Registered read returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
        end else begin
            data_out <= mem[word_index];
        end
    end

endmodule

/* verilog/mem_pkg.sv */
`include "mem_config.svh"

package mem_pkg;

    // Byte address on the core side
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [`MEM_DATA_W-1:0] word_t;

    // Address bits above line index and word offset
    typedef logic [`MEM_ADDR_W-$clog2(`CACHE_LINES)-3:0] tag_t;

    // PWM count, duty and period
    typedef logic [`PWM_W-1:0] pwm_t;

    // L1D controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FETCH,
        FILL,
        WRITE
    } cache_state_t;

endpackage

/* include/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// L1D line count with one word per line
`define CACHE_LINES 16

// Backing RAM size in words
`define RAM_DEPTH 256

// Address map
`define PERIPH_SEL_BIT 31      // Set bit selects the peripherals
`define PERIPH_BTN_OFS 0
`define PERIPH_DUTY_OFS 4
`define PERIPH_PERIOD_OFS 8

// PWM counter width
`define PWM_W 8

`endif
